//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module rx_ring_tb -Mdir obj_dir -f all.f

run: compile
	@out="$$(./obj_dir/Vrx_ring_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- all.f
source/rx_ring_pkg.sv
source/rx_gearbox.sv
source/rx_ring_ram.sv
source/rx_ring_occupancy.sv
source/rx_ring_apb_port.sv
source/rx_ring_top.sv
verif/rx_ring_tb.sv

//--- source/rx_gearbox.sv
// 40-to-64 bit gearbox, residue accumulator with qword emit
`timescale 1ns/1ns

module rx_gearbox (
	input  logic                                reset,
	input  logic                                wrclock,
	input  logic                                enable,
	input  logic                                lane_valid,
	input  logic [rx_ring_pkg::lane_width-1:0]  lane_data,
	output logic                                qword_valid,
	output logic [rx_ring_pkg::qword_width-1:0] qword_data
);
	import rx_ring_pkg::*;

	// up to 63 leftover bits plus one fresh lane word
	logic [lane_width+qword_width-1:0] residue;
	// residue after this cycle's emit, before the append
	logic [lane_width+qword_width-1:0] base;
	// lane word zero extended to residue width
	logic [lane_width+qword_width-1:0] word_ext;
	// number of valid bits in residue, lsb aligned
	logic [6:0]                        pending;
	logic [6:0]                        base_count;
	logic                              take;
	logic                              emit;

	assign word_ext = {{qword_width{1'b0}}, lane_data};

	always_comb begin
		// a full qword is waiting in the low bits
		emit = pending >= 7'(qword_width);
		take = enable & lane_valid;
		if (emit) begin
			base       = residue >> qword_width;
			base_count = pending - 7'(qword_width);
		end else begin
			base       = residue;
			base_count = pending;
		end
	end

	// qword comes straight off the residue register
	assign qword_valid = emit;
	assign qword_data  = residue[qword_width-1:0];

	always_ff @(posedge reset or posedge wrclock) begin
		if (wrclock) begin
			residue <= '0;
			pending <= '0;
		end else if (take) begin
			// new word lands just above the remaining bits
			residue <= base | (word_ext << base_count);
			pending <= base_count + 7'(lane_width);
		end else begin
			residue <= base;
			pending <= base_count;
		end
	end

	// emit every time 64 bits gather keeps the residue from ever spilling
	pending_bound_a: assert property (@(posedge reset) disable iff (wrclock)
		pending <= 7'd103)
		else $error("gearbox pending count overran residue: %0d", pending);

endmodule

//--- source/rx_ring_apb_port.sv
// apb slave, register decode, lane select, pop pulse and capture control
`timescale 1ns/1ns

module rx_ring_apb_port (
	input  logic                                   reset,
	input  logic                                   wrclock,
	input  logic                                   psel,
	input  logic                                   penable,
	input  logic                                   pwrite,
	input  logic [rx_ring_pkg::apb_addr_width-1:0] paddr,
	input  logic [31:0]                            pwdata,
	input  logic [rx_ring_pkg::oword_width-1:0]    oword,
	input  logic [rx_ring_pkg::used_width-1:0]     used,
	input  logic                                   empty,
	input  logic                                   full,
	input  logic                                   almost_full,
	input  logic                                   almost_empty,
	input  logic                                   pop_ok,
	input  logic [rx_ring_pkg::wr_ptr_width-1:0]   wr_ptr,
	input  logic [15:0]                            overflow_count,
	output logic [31:0]                            prdata,
	output logic                                   pready,
	output logic                                   pslverr,
	output logic                                   pop,
	output logic                                   capture_enable
);
	import rx_ring_pkg::*;

	// phase of the current cycle and of the one before
	apb_phase_e  cur_phase;
	apb_phase_e  phase;
	ring_reg_e   reg_sel;
	logic        xfer;
	logic        mapped;
	logic        pop_sel;
	logic [31:0] rd_word;

	always_comb begin
		if (!psel) begin
			cur_phase = idle;
		end else if (!penable) begin
			cur_phase = setup;
		end else begin
			cur_phase = access;
		end
	end

	always_ff @(posedge reset or posedge wrclock) begin
		if (wrclock) begin
			phase <= idle;
		end else begin
			phase <= cur_phase;
		end
	end

	// side effects only once, on the access that follows setup
	assign xfer    = (cur_phase == access) && (phase == setup);
	assign reg_sel = ring_reg_e'(paddr);
	assign pop_sel = pwrite && (reg_sel == reg_pop);

	// --------------------------------------------------
	// read mux and address check
	// --------------------------------------------------
	always_comb begin
		mapped  = 1'b1;
		rd_word = '0;
		case (reg_sel)
			reg_ctrl:   rd_word = {31'b0, capture_enable};
			// flags low, used in 14..8, drops on top
			reg_status: rd_word = {overflow_count, 1'b0, used, 4'b0,
				almost_empty, almost_full, full, empty};
			reg_wptr:   rd_word = {{(32-wr_ptr_width){1'b0}}, wr_ptr};
			reg_pop:    rd_word = '0;
			reg_lane0:  rd_word = oword[31:0];
			reg_lane1:  rd_word = oword[63:32];
			reg_lane2:  rd_word = oword[95:64];
			reg_lane3:  rd_word = oword[127:96];
			default:    mapped  = 1'b0;
		endcase
	end

	// no wait states
	assign pready  = cur_phase == access;
	assign prdata  = (pready && !pwrite) ? rd_word : 32'b0;
	// unmapped address or a pop with less than one oword stored
	assign pslverr = pready && (!mapped || (pop_sel && !pop_ok));
	// occupancy ignores the pulse when pop_ok is low
	assign pop     = xfer && pop_sel;

	always_ff @(posedge reset or posedge wrclock) begin
		if (wrclock) begin
			capture_enable <= 1'b0;
		end else if (xfer && pwrite && reg_sel == reg_ctrl) begin
			capture_enable <= pwdata[0];
		end
	end

	penable_needs_psel_a: assert property (@(posedge reset) disable iff (wrclock)
		$rose(penable) |-> psel)
		else $error("penable raised without psel");

	// every access is entered from a setup or a held access
	access_after_setup_a: assert property (@(posedge reset) disable iff (wrclock)
		cur_phase == access |-> phase != idle)
		else $error("apb access without setup phase");

endmodule

//--- source/rx_ring_occupancy.sv
// ring pointers, used count, status flags and overflow counter
`timescale 1ns/1ns

module rx_ring_occupancy (
	input  logic                                 reset,
	input  logic                                 wrclock,
	input  logic                                 qword_valid,
	input  logic                                 pop,
	output logic                                 wr_en,
	output logic [rx_ring_pkg::wr_ptr_width-1:0] wr_ptr,
	output logic [rx_ring_pkg::rd_ptr_width-1:0] rd_ptr,
	output logic [rx_ring_pkg::used_width-1:0]   used,
	output logic                                 empty,
	output logic                                 full,
	output logic                                 almost_full,
	output logic                                 almost_empty,
	output logic                                 pop_ok,
	output logic [15:0]                          overflow_count
);
	import rx_ring_pkg::*;

	logic do_pop;
	logic drop;

	// --------------------------------------------------
	// flag decode
	// --------------------------------------------------
	assign full         = used == used_width'(ring_depth_qwords);
	// empty means no complete oword to read
	assign empty        = used < used_width'(2);
	assign almost_full  = used >= used_width'(almost_full_level);
	assign almost_empty = used <= used_width'(almost_empty_level);

	// a full ring drops the qword without back pressure to the lane
	assign wr_en  = qword_valid & ~full;
	assign drop   = qword_valid & full;
	// a pop consumes two qwords
	assign pop_ok = ~empty;
	assign do_pop = pop & pop_ok;

	always_ff @(posedge reset or posedge wrclock) begin
		if (wrclock) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			used           <= '0;
			overflow_count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// write and pop may land in the same cycle
			case ({wr_en, do_pop})
				2'b10:   used <= used + used_width'(1);
				2'b01:   used <= used - used_width'(2);
				2'b11:   used <= used - used_width'(1);
				default: used <= used;
			endcase
			// saturating drop counter
			if (drop && overflow_count != 16'hFFFF) begin
				overflow_count <= overflow_count + 16'd1;
			end
		end
	end

	// a cycle that starts full never moves the write pointer
	no_write_when_full_a: assert property (@(posedge reset) disable iff (wrclock)
		full |=> $stable(wr_ptr))
		else $error("ring written while full");

	used_bound_a: assert property (@(posedge reset) disable iff (wrclock)
		used <= used_width'(ring_depth_qwords))
		else $error("used count above ring depth: %0d", used);

	// write pointer leads the read side by exactly the used count
	ptr_distance_a: assert property (@(posedge reset) disable iff (wrclock)
		wr_ptr == wr_ptr_width'({rd_ptr, 1'b0} + used[wr_ptr_width-1:0]))
		else $error("pointer distance disagrees with used count");

endmodule

//--- source/rx_ring_pkg.sv
// ring widths, depth, flag thresholds, register map enum and apb phase enum
package rx_ring_pkg;

	// --------------------------------------------------
	// datapath widths
	// --------------------------------------------------
	// one transceiver word per clock
	localparam int lane_width = 40;
	// ring write side, one qword per gearbox emit
	localparam int qword_width = 64;
	// ring read side, two qwords side by side
	localparam int oword_width = 128;

	// --------------------------------------------------
	// ring geometry and thresholds
	// --------------------------------------------------
	localparam int ring_depth_qwords = 64;
	// qword write address
	localparam int wr_ptr_width = 6;
	// oword read address, one bit narrower than the write side
	localparam int rd_ptr_width = 5;
	// counts 0 to 64 inclusive
	localparam int used_width = 7;
	localparam int almost_full_level = 56;
	localparam int almost_empty_level = 4;

	// apb byte address
	localparam int apb_addr_width = 5;

	// register map, byte addresses
	typedef enum logic [apb_addr_width-1:0] {
		reg_ctrl   = 5'h00,
		reg_status = 5'h04,
		reg_wptr   = 5'h08,
		reg_pop    = 5'h0C,
		reg_lane0  = 5'h10,
		reg_lane1  = 5'h14,
		reg_lane2  = 5'h18,
		reg_lane3  = 5'h1C
	} ring_reg_e;

	// slave side view of the bus phase
	typedef enum logic [1:0] {
		idle,
		setup,
		access
	} apb_phase_e;

endpackage

//--- source/rx_ring_ram.sv
// ring memory, 64-bit write port and registered 128-bit read port
`timescale 1ns/1ns

module rx_ring_ram (
	input  logic                                 reset,
	input  logic                                 wr_en,
	input  logic [rx_ring_pkg::wr_ptr_width-1:0] wr_addr,
	input  logic [rx_ring_pkg::qword_width-1:0]  wr_data,
	input  logic [rx_ring_pkg::rd_ptr_width-1:0] rd_addr,
	output logic [rx_ring_pkg::oword_width-1:0]  rd_data
);
	import rx_ring_pkg::*;

	// one qword per entry
	logic [qword_width-1:0] mem [ring_depth_qwords];

	// even and odd qword of the addressed oword
	logic [wr_ptr_width-1:0] rd_lo_addr;
	logic [wr_ptr_width-1:0] rd_hi_addr;

	assign rd_lo_addr = {rd_addr, 1'b0};
	assign rd_hi_addr = {rd_addr, 1'b1};

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge reset) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// qword 2k in the low half, 2k+1 above it
	// read during write returns the old contents
	always_ff @(posedge reset) begin
		rd_data <= {mem[rd_hi_addr], mem[rd_lo_addr]};
	end

endmodule

//--- source/rx_ring_top.sv
// receive ring top, lane input through gearbox and ring to the apb port
`timescale 1ns/1ns

module rx_ring_top (
	input  logic                                   reset,
	input  logic                                   wrclock,
	input  logic                                   lane_valid,
	input  logic [rx_ring_pkg::lane_width-1:0]     lane_data,
	input  logic                                   psel,
	input  logic                                   penable,
	input  logic                                   pwrite,
	input  logic [rx_ring_pkg::apb_addr_width-1:0] paddr,
	input  logic [31:0]                            pwdata,
	output logic [31:0]                            prdata,
	output logic                                   pready,
	output logic                                   pslverr
);
	import rx_ring_pkg::*;

	// gearbox output
	logic                    qword_valid;
	logic [qword_width-1:0]  qword_data;
	// occupancy state
	logic                    wr_en;
	logic [wr_ptr_width-1:0] wr_ptr;
	logic [rd_ptr_width-1:0] rd_ptr;
	logic [used_width-1:0]   used;
	logic                    empty;
	logic                    full;
	logic                    almost_full;
	logic                    almost_empty;
	logic                    pop_ok;
	logic [15:0]             overflow_count;
	// host side
	logic                    pop;
	logic                    capture_enable;
	logic [oword_width-1:0]  oword;

	// --------------------------------------------------
	// capture path
	// --------------------------------------------------
	rx_gearbox gearbox_i (
		.reset       (reset),
		.wrclock     (wrclock),
		.enable      (capture_enable),
		.lane_valid  (lane_valid),
		.lane_data   (lane_data),
		.qword_valid (qword_valid),
		.qword_data  (qword_data)
	);

	// read address is always the ring read pointer
	rx_ring_ram ram_i (
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_addr (wr_ptr),
		.wr_data (qword_data),
		.rd_addr (rd_ptr),
		.rd_data (oword)
	);

	rx_ring_occupancy occupancy_i (
		.reset          (reset),
		.wrclock        (wrclock),
		.qword_valid    (qword_valid),
		.pop            (pop),
		.wr_en          (wr_en),
		.wr_ptr         (wr_ptr),
		.rd_ptr         (rd_ptr),
		.used           (used),
		.empty          (empty),
		.full           (full),
		.almost_full    (almost_full),
		.almost_empty   (almost_empty),
		.pop_ok         (pop_ok),
		.overflow_count (overflow_count)
	);

	// --------------------------------------------------
	// host access
	// --------------------------------------------------
	rx_ring_apb_port apb_i (
		.reset          (reset),
		.wrclock        (wrclock),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.oword          (oword),
		.used           (used),
		.empty          (empty),
		.full           (full),
		.almost_full    (almost_full),
		.almost_empty   (almost_empty),
		.pop_ok         (pop_ok),
		.wr_ptr         (wr_ptr),
		.overflow_count (overflow_count),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.pop            (pop),
		.capture_enable (capture_enable)
	);

endmodule

//--- verif/rx_ring_tb.sv
// receive ring testbench with clock, reset, xorshift lane words, operation table, model and checks
`timescale 1ns/1ns

module rx_ring_tb;
	import rx_ring_pkg::*;

	// operation codes of the stimulus table
	typedef enum logic [2:0] {
		op_push,
		op_write,
		op_read,
		op_wait,
		op_drain
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [4:0]  addr;
		logic [31:0] data;
		logic        chk;
		logic        exp_err;
	} op_row_t;

	// dut ports where "reset" is the clock and wrclock the reset
	logic                      reset;
	logic                      wrclock;
	logic                      lane_valid;
	logic [lane_width-1:0]     lane_data;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [apb_addr_width-1:0] paddr;
	logic [31:0]               pwdata;
	logic [31:0]               prdata;
	logic                      pready;
	logic                      pslverr;

	op_row_t op_table [$];
	int      checks;
	int      errors;
	int      timeouts;
	logic [31:0] rng_state;

	// --------------------------------------------------
	// reference model state
	// --------------------------------------------------
	// pending lane bits with the oldest first
	bit          bits [$];
	logic [63:0] ring_model [64];
	int          model_used;
	int          model_wptr;
	int          model_rptr;
	logic [15:0] model_overflow;
	logic        model_capture;

	rx_ring_top dut_i (
		.reset      (reset),
		.wrclock    (wrclock),
		.lane_valid (lane_valid),
		.lane_data  (lane_data),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	// 40 ns period
	always #20 reset = ~reset;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// lane bits enter lsb first and one qword leaves per 64 bits
	task automatic model_push_word(input logic [lane_width-1:0] w);
		logic [63:0] q;
		if (model_capture) begin
			for (int i = 0; i < lane_width; i++) begin
				bits.push_back(w[i]);
			end
			while (bits.size() >= 64) begin
				for (int j = 0; j < 64; j++) begin
					q[j] = bits.pop_front();
				end
				// full ring drops the qword
				if (model_used < ring_depth_qwords) begin
					ring_model[model_wptr] = q;
					model_wptr = (model_wptr + 1) % 64;
					model_used = model_used + 1;
				end else if (model_overflow != 16'hFFFF) begin
					model_overflow = model_overflow + 16'd1;
				end
			end
		end
	endtask

	function automatic logic [31:0] expected_status();
		return {model_overflow, 1'b0, 7'(model_used), 4'b0,
			model_used <= almost_empty_level, model_used >= almost_full_level,
			model_used == ring_depth_qwords, model_used < 2};
	endfunction

	function automatic logic [31:0] expected_read(input logic [4:0] addr);
		logic [127:0] ow;
		ow = {ring_model[2*model_rptr+1], ring_model[2*model_rptr]};
		case (addr)
			reg_ctrl:   return {31'b0, model_capture};
			reg_status: return expected_status();
			reg_wptr:   return 32'(model_wptr);
			reg_lane0:  return ow[31:0];
			reg_lane1:  return ow[63:32];
			reg_lane2:  return ow[95:64];
			reg_lane3:  return ow[127:96];
			default:    return 32'b0;
		endcase
	endfunction

	// --------------------------------------------------
	// bus and lane drivers
	// --------------------------------------------------
	task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge reset);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		// setup phase carries no ready and no error
		@(negedge reset);
		checks++;
		if (pready !== 1'b0) begin
			errors++;
			$display("ERR pready setup @%h: got %h expected %h", addr, pready, 1'b0);
		end
		if (pslverr !== 1'b0) begin
			errors++;
			$display("ERR pslverr setup @%h: got %h expected %h", addr, pslverr, 1'b0);
		end
		@(posedge reset);
		penable <= 1'b1;
		waited = 0;
		// sample away from the edge
		@(negedge reset);
		while (!pready && waited < 8) begin
			@(negedge reset);
			waited++;
		end
		rdata = prdata;
		err   = pslverr;
		if (!pready) begin
			timeouts++;
			$display("timeout: pready never rose for address %h", addr);
		end
		@(posedge reset);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic push_words(input int n);
		logic [31:0] hi;
		for (int i = 0; i < n; i++) begin
			rng_state = xorshift32(rng_state);
			hi = rng_state;
			rng_state = xorshift32(rng_state);
			@(posedge reset);
			lane_valid <= 1'b1;
			lane_data  <= {hi[7:0], rng_state};
			model_push_word({hi[7:0], rng_state});
		end
		@(posedge reset);
		lane_valid <= 1'b0;
	endtask

	// poll status until the count and drops settle on the model
	task automatic wait_for_status();
		logic [31:0] rd;
		logic        err;
		int          polls;
		polls = 0;
		rd = ~expected_status();
		while (rd !== expected_status() && polls < 20 && timeouts == 0) begin
			apb_xfer(1'b0, reg_status, 32'b0, rd, err);
			polls++;
		end
		checks++;
		if (rd !== expected_status()) begin
			errors++;
			$display("ERR prdata status: got %h expected %h after %0d reads", rd,
				expected_status(), polls);
		end
	endtask

	// read each lane of the oword at the read pointer and then pop it
	task automatic drain_owords(input int n);
		logic [31:0] rd;
		logic        err;
		logic        exp_err;
		for (int k = 0; k < n; k++) begin
			for (int l = 0; l < 4; l++) begin
				apb_xfer(1'b0, 5'(reg_lane0 + 4 * l), 32'b0, rd, err);
				checks++;
				if (rd !== expected_read(5'(reg_lane0 + 4 * l))) begin
					errors++;
					$display("ERR prdata lane%0d oword %0d: got %h expected %h", l, model_rptr,
						rd, expected_read(5'(reg_lane0 + 4 * l)));
				end
			end
			// a pop needs a whole oword stored
			exp_err = model_used < 2;
			apb_xfer(1'b1, reg_pop, 32'b0, rd, err);
			checks++;
			if (err !== exp_err) begin
				errors++;
				$display("ERR pslverr pop: got %h expected %h", err, exp_err);
			end
			if (model_used >= 2) begin
				model_rptr = (model_rptr + 1) % 32;
				model_used = model_used - 2;
			end
		end
	endtask

	task automatic add_row(input op_e op, input logic [4:0] addr, input logic [31:0] data,
		input logic chk, input logic exp_err);
		op_row_t row;
		row.op      = op;
		row.addr    = addr;
		row.data    = data;
		row.chk     = chk;
		row.exp_err = exp_err;
		op_table.push_back(row);
	endtask

	// --------------------------------------------------
	// operation table
	// --------------------------------------------------
	task automatic init_table();
		// lane0 after reset holds whatever the ram powered up with
		add_row(op_read,  reg_status, 0, 1, 0);
		add_row(op_read,  reg_lane0,  0, 0, 0);
		// words are ignored while capture is disabled
		add_row(op_push,  0,          8, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
		add_row(op_read,  reg_ctrl,   0, 1, 0);
		// 8 words make 5 qwords
		add_row(op_write, reg_ctrl,   1, 0, 0);
		add_row(op_push,  0,          8, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
		add_row(op_read,  reg_wptr,   0, 1, 0);
		add_row(op_drain, 0,          2, 0, 0);
		add_row(op_read,  reg_status, 0, 1, 0);
		// pop refused with one qword left, then unmapped addresses
		add_row(op_write, reg_pop,    0, 0, 1);
		add_row(op_read,  reg_status, 0, 1, 0);
		add_row(op_read,  5'h02,      0, 1, 1);
		add_row(op_write, 5'h06,      5, 0, 1);
		add_row(op_read,  reg_status, 0, 1, 0);
		// 88 words bring the count to 56
		add_row(op_push,  0,         88, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
		add_row(op_read,  reg_wptr,   0, 1, 0);
		// 13 words fill the ring and 16 more are all dropped
		add_row(op_push,  0,         13, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
		add_row(op_read,  reg_wptr,   0, 1, 0);
		add_row(op_push,  0,         16, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
		add_row(op_read,  reg_status, 0, 1, 0);
		add_row(op_drain, 0,         32, 0, 0);
		add_row(op_read,  reg_status, 0, 1, 0);
		add_row(op_write, reg_pop,    0, 0, 1);
		add_row(op_write, reg_ctrl,   0, 0, 0);
		add_row(op_push,  0,          4, 0, 0);
		add_row(op_wait,  0,          0, 0, 0);
	endtask

	initial begin
		op_row_t     row;
		logic [31:0] rd;
		logic        err;
		reset      = 1'b0;
		wrclock    = 1'b1;
		lane_valid = 1'b0;
		lane_data  = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		checks         = 0;
		errors         = 0;
		timeouts       = 0;
		rng_state      = 32'd13503;
		model_used     = 0;
		model_wptr     = 0;
		model_rptr     = 0;
		model_overflow = 16'd0;
		model_capture  = 1'b0;
		init_table();
		repeat (4) @(posedge reset);
		wrclock <= 1'b0;
		for (int r = 0; r < op_table.size() && timeouts == 0; r++) begin
			row = op_table[r];
			case (row.op)
				op_push:  push_words(int'(row.data));
				op_wait:  wait_for_status();
				op_drain: drain_owords(int'(row.data));
				op_write: begin
					apb_xfer(1'b1, row.addr, row.data, rd, err);
					checks++;
					if (err !== row.exp_err) begin
						errors++;
						$display("ERR pslverr write @%h: got %h expected %h", row.addr, err,
							row.exp_err);
					end
					if (row.addr == reg_ctrl) begin
						model_capture = row.data[0];
					end
					// pop only with a whole oword stored
					if (row.addr == reg_pop && model_used >= 2) begin
						model_rptr = (model_rptr + 1) % 32;
						model_used = model_used - 2;
					end
				end
				default: begin
					apb_xfer(1'b0, row.addr, 32'b0, rd, err);
					checks++;
					if (err !== row.exp_err) begin
						errors++;
						$display("ERR pslverr read @%h: got %h expected %h", row.addr, err,
							row.exp_err);
					end
					if (row.chk && rd !== expected_read(row.addr)) begin
						errors++;
						$display("ERR prdata @%h: got %h expected %h", row.addr, rd,
							expected_read(row.addr));
					end
				end
			endcase
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
